// File: Makefile
# Verilator build and run for the fetch front end

VERILATOR  ?= verilator
TOP        ?= tb_fetch_frontend
RTL_TOP    ?= fetch_frontend
FILELIST   ?= project.f
RTL_SRCS   ?= fetch_pkg.sv sync_fifo.sv if1_stage.sv fetch_buffer.sv fetch_frontend.sv
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q ">>> PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer #(
    parameter int BUF_DEPTH = 8
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  buffer_readygo,
    input  wire logic                  decode_allowin,
    input  wire fetch_pkg::inst_t      in_inst0,
    input  wire fetch_pkg::inst_t      in_inst1,
    input  wire fetch_pkg::addr_t      in_pc,
    input  wire fetch_pkg::addr_t      in_pc_next,
    input  wire fetch_pkg::addr_t      in_badv,
    input  wire fetch_pkg::cookie_t    in_cookie,
    input  wire fetch_pkg::excp_code_t in_exception,
    input  wire fetch_pkg::flag_t      in_excp_flag,
    input  wire fetch_pkg::flag_t      in_priv_flag,
    input  wire fetch_pkg::flag_t      in_branch_flag,
    output fetch_pkg::inst_t           fifo_inst0,
    output fetch_pkg::inst_t           fifo_inst1,
    output fetch_pkg::addr_t           fifo_pc,
    output fetch_pkg::addr_t           fifo_pc_add,
    output fetch_pkg::addr_t           fifo_pc_next,
    output fetch_pkg::addr_t           fifo_badv,
    output fetch_pkg::cookie_t         fifo_cookie,
    output fetch_pkg::excp_code_t      fifo_exception,
    output fetch_pkg::flag_t           fifo_excp_flag,
    output fetch_pkg::flag_t           fifo_priv_flag,
    output fetch_pkg::flag_t           fifo_branch_flag,
    output logic                       fifo_valid,
    output logic                       fetch_buf_empty,
    output logic                       fetch_buf_full
);

    localparam int INST_WORD_W  = 2 * $bits(fetch_pkg::inst_t);
    localparam int PCBDV_WORD_W = 3 * $bits(fetch_pkg::addr_t);
    localparam int STAT_WORD_W  = $bits(fetch_pkg::cookie_t) + $bits(fetch_pkg::excp_code_t)
                                + 3 * $bits(fetch_pkg::flag_t);

    logic                    bypass;
    logic                    write_en;
    logic                    pop_en;
    logic [INST_WORD_W-1:0]  inst_din;
    logic [INST_WORD_W-1:0]  inst_dout;
    logic [PCBDV_WORD_W-1:0] pcbdv_din;
    logic [PCBDV_WORD_W-1:0] pcbdv_dout;
    logic [STAT_WORD_W-1:0]  stat_din;
    logic [STAT_WORD_W-1:0]  stat_dout;

    // empty buffer and decode ready, packet goes straight through
    assign bypass   = fetch_buf_empty && buffer_readygo && decode_allowin;
    assign write_en = buffer_readygo && !bypass;
    assign pop_en   = decode_allowin && !bypass;

    assign fifo_valid = !fetch_buf_empty || buffer_readygo;

    // word layouts, low field first
    assign inst_din  = {in_inst1, in_inst0};
    assign pcbdv_din = {in_pc_next, in_pc, in_badv};
    assign stat_din  = {in_branch_flag, in_priv_flag, in_excp_flag, in_exception, in_cookie};

    assign fifo_pc_add = fifo_pc + fetch_pkg::INST_BYTES;

    always_comb begin
        if (bypass) begin
            fifo_inst0       = in_inst0;
            fifo_inst1       = in_inst1;
            fifo_pc          = in_pc;
            fifo_pc_next     = in_pc_next;
            fifo_badv        = in_badv;
            fifo_cookie      = in_cookie;
            fifo_exception   = in_exception;
            fifo_excp_flag   = in_excp_flag;
            fifo_priv_flag   = in_priv_flag;
            fifo_branch_flag = in_branch_flag;
        end else if (!fetch_buf_empty) begin
            // oldest stored packet
            {fifo_inst1, fifo_inst0}              = inst_dout;
            {fifo_pc_next, fifo_pc, fifo_badv}    = pcbdv_dout;
            {fifo_branch_flag, fifo_priv_flag,
             fifo_excp_flag, fifo_exception,
             fifo_cookie}                         = stat_dout;
        end else begin
            // idle, decode sees nops at the boot address
            fifo_inst0       = fetch_pkg::INST_NOP;
            fifo_inst1       = fetch_pkg::INST_NOP;
            fifo_pc          = fetch_pkg::PC_RESET;
            fifo_pc_next     = fetch_pkg::PC_RESET + 32'd8;
            fifo_badv        = fetch_pkg::PC_RESET;
            fifo_cookie      = fetch_pkg::IDLE_COOKIE;
            fifo_exception   = '0;
            fifo_excp_flag   = '0;
            fifo_priv_flag   = '0;
            fifo_branch_flag = '0;
        end
    end

    // the three fifos move together, flags come from inst_buf
    sync_fifo #(
        .DATA_WIDTH (INST_WORD_W),
        .DEPTH      (BUF_DEPTH)
    ) inst_buf (
        .clk      (clk),
        .rst      (rst),
        .write_en (write_en),
        .pop_en   (pop_en),
        .din      (inst_din),
        .dout     (inst_dout),
        .full     (fetch_buf_full),
        .empty    (fetch_buf_empty)
    );

    sync_fifo #(
        .DATA_WIDTH (PCBDV_WORD_W),
        .DEPTH      (BUF_DEPTH)
    ) pcbdv_buf (
        .clk      (clk),
        .rst      (rst),
        .write_en (write_en),
        .pop_en   (pop_en),
        .din      (pcbdv_din),
        .dout     (pcbdv_dout),
        .full     (),
        .empty    ()
    );

    sync_fifo #(
        .DATA_WIDTH (STAT_WORD_W),
        .DEPTH      (BUF_DEPTH)
    ) stat_buf (
        .clk      (clk),
        .rst      (rst),
        .write_en (write_en),
        .pop_en   (pop_en),
        .din      (stat_din),
        .dout     (stat_dout),
        .full     (),
        .empty    ()
    );

endmodule

`default_nettype wire

// File: fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend #(
    parameter int BUF_DEPTH = 8
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  fetch_valid,
    input  wire fetch_pkg::inst_t      inst0,
    input  wire fetch_pkg::inst_t      inst1,
    input  wire fetch_pkg::addr_t      pc,
    input  wire fetch_pkg::addr_t      pc_next,
    input  wire fetch_pkg::addr_t      badv,
    input  wire fetch_pkg::cookie_t    cookie,
    input  wire fetch_pkg::excp_code_t exception,
    input  wire fetch_pkg::flag_t      excp_flag,
    input  wire fetch_pkg::flag_t      priv_flag,
    input  wire fetch_pkg::flag_t      branch_flag,
    output logic                       fetch_ready,
    input  wire logic                  decode_allowin,
    output fetch_pkg::inst_t           fifo_inst0,
    output fetch_pkg::inst_t           fifo_inst1,
    output fetch_pkg::addr_t           fifo_pc,
    output fetch_pkg::addr_t           fifo_pc_add,
    output fetch_pkg::addr_t           fifo_pc_next,
    output fetch_pkg::addr_t           fifo_badv,
    output fetch_pkg::cookie_t         fifo_cookie,
    output fetch_pkg::excp_code_t      fifo_exception,
    output fetch_pkg::flag_t           fifo_excp_flag,
    output fetch_pkg::flag_t           fifo_priv_flag,
    output fetch_pkg::flag_t           fifo_branch_flag,
    output logic                       fifo_valid,
    output logic                       fetch_buf_empty,
    output logic                       fetch_buf_full
);

    // if1 to buffer
    logic                  buffer_readygo;
    fetch_pkg::inst_t      if1_inst0;
    fetch_pkg::inst_t      if1_inst1;
    fetch_pkg::addr_t      if1_pc;
    fetch_pkg::addr_t      if1_pc_next;
    fetch_pkg::addr_t      if1_badv;
    fetch_pkg::cookie_t    if1_cookie;
    fetch_pkg::excp_code_t if1_exception;
    fetch_pkg::flag_t      if1_excp_flag;
    fetch_pkg::flag_t      if1_priv_flag;
    fetch_pkg::flag_t      if1_branch_flag;

    if1_stage u_if1 (
        .clk             (clk),
        .rst             (rst),
        .fetch_valid     (fetch_valid),
        .buf_full        (fetch_buf_full),
        .inst0           (inst0),
        .inst1           (inst1),
        .pc              (pc),
        .pc_next         (pc_next),
        .badv            (badv),
        .cookie          (cookie),
        .exception       (exception),
        .excp_flag       (excp_flag),
        .priv_flag       (priv_flag),
        .branch_flag     (branch_flag),
        .fetch_ready     (fetch_ready),
        .buffer_readygo  (buffer_readygo),
        .if1_inst0       (if1_inst0),
        .if1_inst1       (if1_inst1),
        .if1_pc          (if1_pc),
        .if1_pc_next     (if1_pc_next),
        .if1_badv        (if1_badv),
        .if1_cookie      (if1_cookie),
        .if1_exception   (if1_exception),
        .if1_excp_flag   (if1_excp_flag),
        .if1_priv_flag   (if1_priv_flag),
        .if1_branch_flag (if1_branch_flag)
    );

    fetch_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_fetch_buffer (
        .clk              (clk),
        .rst              (rst),
        .buffer_readygo   (buffer_readygo),
        .decode_allowin   (decode_allowin),
        .in_inst0         (if1_inst0),
        .in_inst1         (if1_inst1),
        .in_pc            (if1_pc),
        .in_pc_next       (if1_pc_next),
        .in_badv          (if1_badv),
        .in_cookie        (if1_cookie),
        .in_exception     (if1_exception),
        .in_excp_flag     (if1_excp_flag),
        .in_priv_flag     (if1_priv_flag),
        .in_branch_flag   (if1_branch_flag),
        .fifo_inst0       (fifo_inst0),
        .fifo_inst1       (fifo_inst1),
        .fifo_pc          (fifo_pc),
        .fifo_pc_add      (fifo_pc_add),
        .fifo_pc_next     (fifo_pc_next),
        .fifo_badv        (fifo_badv),
        .fifo_cookie      (fifo_cookie),
        .fifo_exception   (fifo_exception),
        .fifo_excp_flag   (fifo_excp_flag),
        .fifo_priv_flag   (fifo_priv_flag),
        .fifo_branch_flag (fifo_branch_flag),
        .fifo_valid       (fifo_valid),
        .fetch_buf_empty  (fetch_buf_empty),
        .fetch_buf_full   (fetch_buf_full)
    );

endmodule

`default_nettype wire

// File: fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // field widths of one fetch packet
    localparam int INST_W      = 32;
    localparam int ADDR_W      = 32;
    localparam int COOKIE_W    = 32;
    localparam int EXCP_CODE_W = 7;
    localparam int FLAG_W      = 2;

    // one instruction word
    typedef logic [INST_W-1:0] inst_t;

    // virtual address, used for pc, pc_next and badv
    typedef logic [ADDR_W-1:0] addr_t;

    // cache cookie carried with each packet
    typedef logic [COOKIE_W-1:0] cookie_t;

    // instruction fetch exception code
    typedef logic [EXCP_CODE_W-1:0] excp_code_t;

    // exception, privilege and branch flags
    typedef logic [FLAG_W-1:0] flag_t;

    // loongarch nop, andi r0, r0, 0
    localparam inst_t INST_NOP = 32'h0340_0000;

    // boot address of the core
    localparam addr_t PC_RESET = 32'h1c00_0000;

    // cookie shown while the buffer has nothing to offer
    localparam cookie_t IDLE_COOKIE = 32'd1919810;

    // byte step between the two instructions of a packet
    localparam addr_t INST_BYTES = 32'd4;

endpackage

`default_nettype wire

// File: if1_stage.sv
`timescale 1ns/1ps
`default_nettype none

module if1_stage (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  fetch_valid,
    input  wire logic                  buf_full,
    input  wire fetch_pkg::inst_t      inst0,
    input  wire fetch_pkg::inst_t      inst1,
    input  wire fetch_pkg::addr_t      pc,
    input  wire fetch_pkg::addr_t      pc_next,
    input  wire fetch_pkg::addr_t      badv,
    input  wire fetch_pkg::cookie_t    cookie,
    input  wire fetch_pkg::excp_code_t exception,
    input  wire fetch_pkg::flag_t      excp_flag,
    input  wire fetch_pkg::flag_t      priv_flag,
    input  wire fetch_pkg::flag_t      branch_flag,
    output logic                       fetch_ready,
    output logic                       buffer_readygo,
    output fetch_pkg::inst_t           if1_inst0,
    output fetch_pkg::inst_t           if1_inst1,
    output fetch_pkg::addr_t           if1_pc,
    output fetch_pkg::addr_t           if1_pc_next,
    output fetch_pkg::addr_t           if1_badv,
    output fetch_pkg::cookie_t         if1_cookie,
    output fetch_pkg::excp_code_t      if1_exception,
    output fetch_pkg::flag_t           if1_excp_flag,
    output fetch_pkg::flag_t           if1_priv_flag,
    output fetch_pkg::flag_t           if1_branch_flag
);

    logic if1_valid;
    logic load;

    // held packet leaves whenever the buffer has room
    assign buffer_readygo = if1_valid && !buf_full;

    // register free, or emptied this cycle
    assign fetch_ready = !if1_valid || buffer_readygo;
    assign load        = fetch_valid && fetch_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            if1_valid <= 1'b0;
        end else if (load) begin
            if1_valid <= 1'b1;
        end else if (buffer_readygo) begin
            if1_valid <= 1'b0;
        end
    end

    // packet payload, only meaningful while if1_valid
    always_ff @(posedge clk) begin
        if (load) begin
            if1_inst0       <= inst0;
            if1_inst1       <= inst1;
            if1_pc          <= pc;
            if1_pc_next     <= pc_next;
            if1_badv        <= badv;
            if1_cookie      <= cookie;
            if1_exception   <= exception;
            if1_excp_flag   <= excp_flag;
            if1_priv_flag   <= priv_flag;
            if1_branch_flag <= branch_flag;
        end
    end

endmodule

`default_nettype wire

// File: project.f
fetch_pkg.sv
sync_fifo.sv
if1_stage.sv
fetch_buffer.sv
fetch_frontend.sv
tb_fetch_frontend.sv

// File: sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 8
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  write_en,
    input  wire logic                  pop_en,
    input  wire logic [DATA_WIDTH-1:0] din,
    output logic      [DATA_WIDTH-1:0] dout,
    output logic                       full,
    output logic                       empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  push_ok;
    logic                  pop_ok;

    // full and empty requests are dropped here
    assign push_ok = write_en && !full;
    assign pop_ok  = pop_en && !empty;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // first word fall through, head is always on dout
    assign dout = mem[rd_ptr];

    // storage array
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= din;
        end
    end

    // pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_ok) begin
                if (wr_ptr == PTR_W'(DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop_ok) begin
                if (rd_ptr == PTR_W'(DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    // occupancy, unchanged on simultaneous push and pop
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (push_ok && !pop_ok) begin
            count <= count + 1'b1;
        end else if (pop_ok && !push_ok) begin
            count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: tb_fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_frontend;

    localparam int BUF_DEPTH = 8;
    localparam int PKT_W     = 205;
    localparam int N_FIELDS  = 10;
    localparam int N_ROWS    = 17;

    // packet layout, msb first: inst1 inst0 pc_next pc badv branch priv excp_flag exception cookie
    localparam int FIELD_W [N_FIELDS] = '{32, 32, 32, 32, 32, 2, 2, 2, 7, 32};

    localparam logic [PKT_W-1:0] IDLE_PKT = {32'h0340_0000, 32'h0340_0000, 32'h1c00_0008,
        32'h1c00_0000, 32'h1c00_0000, 2'b00, 2'b00, 2'b00, 7'h00, 32'd1919810};

    // per row: fetch_valid, decode_allowin (2 means random), cycles, empty expected
    localparam int ROW_VALID  [N_ROWS] = '{1, 0, 1, 0, 1, 0, 1, 0, 1, 0, 2, 1, 2, 2, 1, 2, 0};
    localparam int ROW_ALLOW  [N_ROWS] = '{1, 1, 1, 1, 1, 1, 1, 1, 0, 1, 2, 2, 1, 0, 1, 2, 1};
    localparam int ROW_CYCLES [N_ROWS] = '{1, 3, 1, 3, 1, 2, 6, 2, 14, 12, 40, 24, 24, 10, 10,
                                           30, 14};
    localparam int ROW_EMPTY  [N_ROWS] = '{1, 1, 1, 1, 1, 1, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0};

    logic             clk;
    logic             rst;
    logic             fetch_valid;
    logic             decode_allowin;
    logic [PKT_W-1:0] drv_pkt;
    logic [31:0]      lfsr;

    wire [PKT_W-1:0] out_pkt;
    wire [31:0]      fifo_pc_add;
    wire             fetch_ready;
    wire             fifo_valid;
    wire             fetch_buf_empty;
    wire             fetch_buf_full;

    // values seen at the last rising edge
    logic [PKT_W-1:0] snap_pkt;
    logic [31:0]      snap_pc_add;
    logic             snap_fv;
    logic             snap_allow;
    logic             snap_ready;
    logic             snap_valid;
    logic             snap_empty;
    logic             snap_full;

    // reference model of the if1 register and the buffer occupancy
    logic             m_if1;
    int               m_cnt;
    int               cyc;
    int               max_q;
    logic             chk_empty;
    logic             took;
    logic [PKT_W-1:0] pkt_q [$];
    int               acc_q [$];

    fetch_frontend #(
        .BUF_DEPTH (BUF_DEPTH)
    ) dut0 (
        .clk              (clk),
        .rst              (rst),
        .fetch_valid      (fetch_valid),
        .inst0            (drv_pkt[172:141]),
        .inst1            (drv_pkt[204:173]),
        .pc               (drv_pkt[108:77]),
        .pc_next          (drv_pkt[140:109]),
        .badv             (drv_pkt[76:45]),
        .cookie           (drv_pkt[31:0]),
        .exception        (drv_pkt[38:32]),
        .excp_flag        (drv_pkt[40:39]),
        .priv_flag        (drv_pkt[42:41]),
        .branch_flag      (drv_pkt[44:43]),
        .fetch_ready      (fetch_ready),
        .decode_allowin   (decode_allowin),
        .fifo_inst0       (out_pkt[172:141]),
        .fifo_inst1       (out_pkt[204:173]),
        .fifo_pc          (out_pkt[108:77]),
        .fifo_pc_add      (fifo_pc_add),
        .fifo_pc_next     (out_pkt[140:109]),
        .fifo_badv        (out_pkt[76:45]),
        .fifo_cookie      (out_pkt[31:0]),
        .fifo_exception   (out_pkt[38:32]),
        .fifo_excp_flag   (out_pkt[40:39]),
        .fifo_priv_flag   (out_pkt[42:41]),
        .fifo_branch_flag (out_pkt[44:43]),
        .fifo_valid       (fifo_valid),
        .fetch_buf_empty  (fetch_buf_empty),
        .fetch_buf_full   (fetch_buf_full)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // pre-edge values, before any register update of this edge
    always @(posedge clk) begin
        snap_pkt    <= out_pkt;
        snap_pc_add <= fifo_pc_add;
        snap_fv     <= fetch_valid;
        snap_allow  <= decode_allowin;
        snap_ready  <= fetch_ready;
        snap_valid  <= fifo_valid;
        snap_empty  <= fetch_buf_empty;
        snap_full   <= fetch_buf_full;
    end

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic logic pick_level(input int mode);
        logic [31:0] b;
        b = (mode == 2) ? take_bits(1) : 32'(mode);
        return b[0];
    endfunction

    task automatic draw_packet();
        logic [PKT_W-1:0] p;
        p = '0;
        for (int i = 0; i < N_FIELDS; i++) begin
            p = (p << FIELD_W[i]) | PKT_W'(take_bits(FIELD_W[i]));
        end
        drv_pkt = p;
    endtask

    // compare one edge with the model, then advance the model past it
    task automatic check_cycle();
        logic readygo;
        logic ready;
        logic valid;
        logic bypass;
        logic wr;
        logic pop;
        readygo = m_if1 && (m_cnt < BUF_DEPTH);
        ready   = !m_if1 || readygo;
        valid   = (m_cnt > 0) || readygo;
        bypass  = (m_cnt == 0) && readygo && snap_allow;
        wr      = readygo && !bypass;
        pop     = snap_allow && !bypass && (m_cnt > 0);
        assert (snap_ready == ready && snap_valid == valid)
            else report_error($sformatf("fetch_ready %b fifo_valid %b, expected %b %b",
                snap_ready, snap_valid, ready, valid));
        assert (snap_empty == (m_cnt == 0) && snap_full == (m_cnt == BUF_DEPTH))
            else report_error($sformatf("empty %b full %b with %0d packets stored",
                snap_empty, snap_full, m_cnt));
        assert (snap_pc_add == snap_pkt[108:77] + 32'd4)
            else report_error($sformatf("fifo_pc_add %h for fifo_pc %h",
                snap_pc_add, snap_pkt[108:77]));
        if (!snap_valid) begin
            assert (snap_pkt == IDLE_PKT)
                else report_error($sformatf("idle outputs %h, expected %h", snap_pkt, IDLE_PKT));
        end
        if (chk_empty) begin
            assert (snap_empty) else report_error("fetch_buf_empty low during bypass traffic");
        end
        // deepest queue seen while the dut reports full and not ready
        if (snap_full && !snap_ready && pkt_q.size() > max_q) begin
            max_q = pkt_q.size();
        end
        if (snap_valid && snap_allow) begin
            assert (pkt_q.size() > 0) else report_error("delivered a packet never accepted");
            assert (snap_pkt == pkt_q[0])
                else report_error($sformatf("delivered %h, expected %h", snap_pkt, pkt_q[0]));
            if (chk_empty) begin
                assert (cyc == acc_q[0] + 1)
                    else report_error($sformatf("bypass after %0d cycles, expected 1",
                        cyc - acc_q[0]));
            end
            void'(pkt_q.pop_front());
            void'(acc_q.pop_front());
        end
        took  = snap_fv && ready;
        m_cnt = m_cnt + int'(wr) - int'(pop);
        if (took) begin
            m_if1 = 1'b1;
            pkt_q.push_back(drv_pkt);
            acc_q.push_back(cyc);
        end else if (readygo) begin
            m_if1 = 1'b0;
        end
        cyc++;
    endtask

    initial begin
        int limit;
        limit = 50;
        for (int r = 0; r < N_ROWS; r++) begin
            limit += ROW_CYCLES[r];
        end
        #(limit * 100);
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst            = 1'b1;
        fetch_valid    = 1'b0;
        decode_allowin = 1'b0;
        drv_pkt        = '0;
        lfsr           = 32'h7777_0d98;
        m_if1          = 1'b0;
        m_cnt          = 0;
        cyc            = 0;
        max_q          = 0;
        chk_empty      = 1'b0;
        took           = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        assert (fetch_buf_empty && !fetch_buf_full && !fifo_valid && fetch_ready)
            else report_error("flags do not show an empty front end after reset");
        assert (out_pkt == IDLE_PKT && fifo_pc_add == 32'h1c00_0004)
            else report_error($sformatf("outputs after reset %h, expected %h", out_pkt, IDLE_PKT));
        rst = 1'b0;
        draw_packet();
        for (int r = 0; r < N_ROWS; r++) begin
            for (int k = 0; k < ROW_CYCLES[r]; k++) begin
                @(negedge clk);
                check_cycle();
                if (took) begin
                    draw_packet();
                end
                fetch_valid    = pick_level(ROW_VALID[r]);
                decode_allowin = pick_level(ROW_ALLOW[r]);
                chk_empty      = ROW_EMPTY[r][0];
            end
        end
        @(negedge clk);
        check_cycle();
        assert (max_q == BUF_DEPTH + 1)
            else report_error($sformatf("at most %0d packets in flight, expected %0d",
                max_q, BUF_DEPTH + 1));
        assert (pkt_q.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            report_error($sformatf("%0d accepted packets never delivered", pkt_q.size()));
        end
    end

endmodule

`default_nettype wire
